// File: hisSubsystem.f
+incdir+verilog
verilog/hisBuilderPkg.sv
verilog/countStream.sv
verilog/binMapper.sv
verilog/hisBuilderReg.sv
verilog/peakTracker.sv
verilog/hisSubsystem.sv
verification/hisSubsystemTb.sv

// File: Bender.yml
package:
  name: hisSubsystem

sources:
  # histogram RTL, top level hisSubsystem
  - include_dirs:
      - verilog
    files:
      - verilog/hisBuilderPkg.sv
      - verilog/countStream.sv
      - verilog/binMapper.sv
      - verilog/hisBuilderReg.sv
      - verilog/peakTracker.sv
      - verilog/hisSubsystem.sv

  # testbench top hisSubsystemTb
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/hisSubsystemTb.sv

// File: verification/hisSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

module hisSubsystemTb import hisBuilderPkg::*; ();

    localparam int FrameCycles = `HIS_FRAME_CYCLES;
    localparam int NumFrames   = 6;
    localparam int EmptyFrame  = 3;    // stamp frame index left without events
    localparam int NumTests    = 5;
    localparam int TMap        = 0;
    localparam int TRange      = 1;
    localparam int TCount      = 2;
    localparam int TFrame      = 3;
    localparam int TPeak       = 4;
    localparam logic [`HIS_TS_W-1:0]    Offset   = `HIS_TS_W'(100);
    localparam logic [`HIS_COUNT_W-1:0] CountMax = '1;
    localparam logic [31:0]             Seed     = 32'h8479_44d7;

    logic                    clk = 1'b0;
    logic                    res;
    logic                    stampValid;
    logic [`HIS_TS_W-1:0]    stamp;
    logic                    coarseMode;
    logic [`HIS_TS_W-1:0]    offset;
    logic                    countValid;
    logic [`HIS_BIN_W-1:0]   countBin;
    logic [`HIS_COUNT_W-1:0] count;
    logic                    outOfRange;
    logic                    frameDone;
    logic                    nextFlag;
    logic                    peakValid;
    logic [`HIS_BIN_W-1:0]   peakBin;
    logic [`HIS_COUNT_W-1:0] peakCount;

    // model state
    logic [31:0]              lfsr = Seed;
    int                       edgeNum = 0;       // posedges since reset release
    int                       curFrame = -1;
    hisRes                    curRes = resFine;
    logic [`HIS_TS_W-1:0]     lastStamp = '0;
    logic                     pendValid = 1'b0;  // driven this cycle
    logic                     pendInRange = 1'b0;
    logic [`HIS_BIN_W-1:0]    pendBin = '0;
    logic                     aValid = 1'b0;     // one cycle old
    logic                     aInRange = 1'b0;
    logic [`HIS_BIN_W-1:0]    aBin = '0;
    logic                     bValid = 1'b0;     // two cycles old
    logic                     bInRange = 1'b0;
    logic [`HIS_BIN_W-1:0]    bBin = '0;
    logic [`HIS_NUM_BINS-1:0] seenModel = '0;
    logic [`HIS_COUNT_W-1:0]  cntModel [`HIS_NUM_BINS];
    logic [`HIS_COUNT_W-1:0]  maxCount = '0;
    logic [`HIS_BIN_W-1:0]    maxBin = '0;
    logic [`HIS_COUNT_W-1:0]  heldCount = '0;
    logic [`HIS_BIN_W-1:0]    heldBin = '0;
    logic                     expFlag = 1'b0;
    logic                     timedOut = 1'b0;
    int                       passCnt [NumTests] = '{default: 0};
    int                       errCnt [NumTests] = '{default: 0};
    string                    testName [NumTests];

    hisSubsystem i_dut (
        .clk        (clk),
        .res        (res),
        .stampValid (stampValid),
        .stamp      (stamp),
        .coarseMode (coarseMode),
        .offset     (offset),
        .countValid (countValid),
        .countBin   (countBin),
        .count      (count),
        .outOfRange (outOfRange),
        .frameDone  (frameDone),
        .nextFlag   (nextFlag),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    always #5 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic noteErr(input int id, input string name, input logic [31:0] exp,
                           input logic [31:0] got);
        $display("ERR t=%0t %s exp %0d got %0d", $time, name, exp, got);
        errCnt[id]++;
    endtask

    task automatic notePass(input int id);
        passCnt[id]++;
    endtask

    // next stamp, classified by the histogram rules
    task automatic driveStamp();
        int                   frameIdx;
        int                   kind;
        logic                 vld;
        logic                 below;
        logic [`HIS_TS_W-1:0] st;
        logic [`HIS_TS_W-1:0] diff;
        logic [`HIS_TS_W-1:0] shifted;
        frameIdx = (edgeNum + 2) / FrameCycles;
        if (frameIdx != curFrame) begin
            curFrame = frameIdx;
            if (frameIdx < 2) begin
                curRes = (frameIdx == 1) ? resCoarse : resFine;
            end else begin
                curRes = randBits(1) ? resCoarse : resFine;
            end
        end
        vld  = (randBits(2) != 0) && (frameIdx != EmptyFrame);
        kind = randBits(3);
        if (((edgeNum + 2) % FrameCycles == 0) && (frameIdx != EmptyFrame)) begin
            vld  = 1'b1;   // aim an in-range event at the wrap edge
            kind = 7;
        end
        case (kind)
            0: st = `HIS_TS_W'(randBits(6));   // below offset
            1: begin
                if (curRes == resCoarse) begin
                    st = Offset + `HIS_TS_W'(`HIS_NUM_BINS << `HIS_COARSE_SHIFT);
                end else begin
                    st = Offset + `HIS_TS_W'(`HIS_NUM_BINS << `HIS_FINE_SHIFT);
                end
                st = st + `HIS_TS_W'(randBits(4));   // just past the last bin
            end
            2: st = lastStamp;                 // back-to-back repeat
            default: begin
                if (curRes == resCoarse) begin
                    st = Offset + `HIS_TS_W'(randBits(`HIS_BIN_W + `HIS_COARSE_SHIFT));
                end else begin
                    st = Offset + `HIS_TS_W'(randBits(`HIS_BIN_W + `HIS_FINE_SHIFT));
                end
            end
        endcase
        below = st < Offset;
        diff  = st - Offset;
        if (curRes == resCoarse) begin
            shifted = diff >> `HIS_COARSE_SHIFT;
        end else begin
            shifted = diff >> `HIS_FINE_SHIFT;
        end
        pendValid   = vld;
        pendInRange = !below && (shifted < `HIS_NUM_BINS);
        pendBin     = shifted[`HIS_BIN_W-1:0];
        lastStamp   = st;
        stampValid  = vld;
        stamp       = st;
        coarseMode  = (curRes == resCoarse);
    endtask

    // one clock: check what the last posedge produced, then drive
    task automatic stepCycle();
        logic                    wrapEdge;
        logic                    expCv;
        logic                    expPv;
        logic [`HIS_COUNT_W-1:0] expCount;
        int                      id;
        @(negedge clk);
        edgeNum++;
        bValid   = aValid;
        bInRange = aInRange;
        bBin     = aBin;
        aValid   = pendValid;
        aInRange = pendInRange;
        aBin     = pendBin;
        wrapEdge = (edgeNum % FrameCycles == 0);
        if (wrapEdge) begin
            seenModel = '0;
            expFlag   = ~expFlag;
            heldBin   = maxBin;
            heldCount = maxCount;
            maxBin    = '0;
            maxCount  = '0;
        end
        if (frameDone !== wrapEdge) noteErr(TFrame, "frameDone", wrapEdge, frameDone);
        else notePass(TFrame);
        if (nextFlag !== expFlag) noteErr(TFrame, "nextFlag", expFlag, nextFlag);
        else notePass(TFrame);
        if (outOfRange !== (aValid && !aInRange))
            noteErr(TRange, "outOfRange", aValid && !aInRange, outOfRange);
        else notePass(TRange);
        expCv = bValid && bInRange && !wrapEdge;
        if (wrapEdge) id = TFrame;
        else if (bValid && !bInRange) id = TRange;
        else id = TMap;
        if (countValid !== expCv) noteErr(id, "countValid", expCv, countValid);
        else notePass(id);
        if (expCv) begin
            if (!seenModel[bBin]) begin
                cntModel[bBin]  = `HIS_COUNT_W'(1);
                seenModel[bBin] = 1'b1;
            end else if (cntModel[bBin] != CountMax) begin
                cntModel[bBin] = cntModel[bBin] + 1'b1;
            end
            expCount = cntModel[bBin];
            if (countBin !== bBin) noteErr(TMap, "countBin", bBin, countBin);
            else notePass(TMap);
            id = (expCount == 1 && edgeNum > FrameCycles) ? TFrame : TCount;
            if (count !== expCount) noteErr(id, "count", expCount, count);
            else notePass(id);
            if (expCount > maxCount) begin
                maxCount = expCount;
                maxBin   = bBin;
            end
        end
        expPv = (edgeNum % FrameCycles == 1) && (edgeNum > FrameCycles);
        if (peakValid !== expPv) noteErr(TPeak, "peakValid", expPv, peakValid);
        else notePass(TPeak);
        if (expPv) begin
            if (peakBin !== heldBin) noteErr(TPeak, "peakBin", heldBin, peakBin);
            else notePass(TPeak);
            if (peakCount !== heldCount) noteErr(TPeak, "peakCount", heldCount, peakCount);
            else notePass(TPeak);
        end
        driveStamp();
    endtask

    initial begin
        int waited;
        int totalPass;
        int totalErr;
        testName[TMap]   = "bin mapping";
        testName[TRange] = "range reject";
        testName[TCount] = "counting";
        testName[TFrame] = "frame boundary";
        testName[TPeak]  = "peak report";
        res        = 1'b0;
        stampValid = 1'b0;
        stamp      = '0;
        coarseMode = 1'b0;
        offset     = Offset;
        repeat (10) @(negedge clk);
        res = 1'b1;
        driveStamp();
        for (int f = 0; f < NumFrames && !timedOut; f++) begin
            waited = 0;
            do begin
                stepCycle();
                waited++;
            end while (frameDone !== 1'b1 && waited < FrameCycles + 8);
            if (frameDone !== 1'b1) begin
                timedOut = 1'b1;
                $display("timeout: frame %0d ended without frameDone", f);
            end
        end
        if (!timedOut) begin
            waited = 0;
            do begin
                stepCycle();
                waited++;
            end while (peakValid !== 1'b1 && waited < 8);
            if (peakValid !== 1'b1) begin
                timedOut = 1'b1;
                $display("timeout: no peak report after the last frame");
            end
        end
        totalPass = 0;
        totalErr  = 0;
        for (int t = 0; t < NumTests; t++) begin
            $display("test %s: %0d checks passed, %0d errors", testName[t], passCnt[t],
                     errCnt[t]);
            totalPass += passCnt[t];
            totalErr  += errCnt[t];
        end
        $display("total: %0d passed, %0d errors", totalPass, totalErr);
        if (timedOut || totalErr != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/hisSubsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

module hisSubsystem import hisBuilderPkg::*; (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    stampValid,
    input  logic [`HIS_TS_W-1:0]    stamp,
    input  logic                    coarseMode,
    input  logic [`HIS_TS_W-1:0]    offset,
    output logic                    countValid,
    output logic [`HIS_BIN_W-1:0]   countBin,
    output logic [`HIS_COUNT_W-1:0] count,
    output logic                    outOfRange,
    output logic                    frameDone,
    output logic                    nextFlag,
    output logic                    peakValid,
    output logic [`HIS_BIN_W-1:0]   peakBin,
    output logic [`HIS_COUNT_W-1:0] peakCount
);

    hisRes                 resSel;
    logic                  binValid;
    logic [`HIS_BIN_W-1:0] binAddr;

    countStream cntIf ();

    assign resSel = hisRes'(coarseMode);   // 1 selects coarse bins

    binMapper i_binMapper (
        .clk        (clk),
        .res        (res),
        .stampValid (stampValid),
        .stamp      (stamp),
        .resSel     (resSel),
        .offset     (offset),
        .binValid   (binValid),
        .binAddr    (binAddr),
        .outOfRange (outOfRange)
    );

    hisBuilderReg i_hisBuilderReg (
        .clk      (clk),
        .res      (res),
        .binValid (binValid),
        .binAddr  (binAddr),
        .cnt      (cntIf.src),
        .nextFlag (nextFlag)
    );

    peakTracker i_peakTracker (
        .clk       (clk),
        .res       (res),
        .cnt       (cntIf.dst),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    // per-event results brought out as plain ports
    assign countValid = cntIf.valid;
    assign countBin   = cntIf.bin;
    assign count      = cntIf.count;
    assign frameDone  = cntIf.frameDone;

endmodule

`default_nettype wire

// File: verilog/peakTracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

module peakTracker import hisBuilderPkg::*; (
    input  logic                    clk,
    input  logic                    res,
    countStream.dst                 cnt,
    output logic                    peakValid,
    output logic [`HIS_BIN_W-1:0]   peakBin,
    output logic [`HIS_COUNT_W-1:0] peakCount
);

    logic [`HIS_COUNT_W-1:0] maxCount;
    logic [`HIS_BIN_W-1:0]   maxBin;
    logic                    newMax;

    // strict compare, earliest bin keeps a tie
    assign newMax = cnt.valid && (cnt.count > maxCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            maxCount  <= '0;
            maxBin    <= '0;
            peakValid <= 1'b0;
        end else if (cnt.frameDone) begin
            maxCount  <= '0;       // restart for the next frame
            maxBin    <= '0;
            peakValid <= 1'b1;
        end else begin
            peakValid <= 1'b0;
            if (newMax) begin
                maxCount <= cnt.count;
                maxBin   <= cnt.bin;
            end
        end
    end

    // frame result, held until the next frame end
    always_ff @(posedge clk) begin
        if (cnt.frameDone) begin
            peakBin   <= maxBin;
            peakCount <= maxCount;
        end
    end

    aPeakAfterDone: assert property (
        @(posedge clk) disable iff (!res)
        peakValid |-> $past(cnt.frameDone)
    ) else $error("peakTracker: peakValid without preceding frameDone");

endmodule

`default_nettype wire

// File: verilog/hisBuilderReg.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

module hisBuilderReg import hisBuilderPkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  binValid,
    input  logic [`HIS_BIN_W-1:0] binAddr,
    countStream.src               cnt,
    output logic                  nextFlag
);

    localparam int FrameCntW = $clog2(`HIS_FRAME_CYCLES);
    localparam logic [`HIS_COUNT_W-1:0] CountMax = '1;

    logic [`HIS_COUNT_W-1:0]  binMem [`HIS_NUM_BINS];
    logic [`HIS_NUM_BINS-1:0] binSeen;   // per-bin valid bits, lazy clear
    logic [FrameCntW-1:0]     frameCnt;
    frameState                state;
    logic                     wrap;

    logic [`HIS_COUNT_W-1:0]  storedCount;
    logic [`HIS_COUNT_W-1:0]  nextCount;

    logic                     hitValid;
    logic [`HIS_BIN_W-1:0]    hitBin;
    logic [`HIS_COUNT_W-1:0]  hitCount;

    assign wrap = (frameCnt == FrameCntW'(`HIS_FRAME_CYCLES - 1));

    // read-modify-write of the addressed bin, all within one cycle
    always_comb begin
        storedCount = binMem[binAddr];
        if (!binSeen[binAddr]) begin
            nextCount = `HIS_COUNT_W'(1);    // stale content from an older frame
        end else if (storedCount == CountMax) begin
            nextCount = storedCount;         // saturate
        end else begin
            nextCount = storedCount + 1'b1;
        end
    end

    // frame counter and phase
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frameCnt <= '0;
            state    <= frameAcquire;
            nextFlag <= 1'b0;
        end else if (wrap) begin
            frameCnt <= '0;
            state    <= frameClose;
            nextFlag <= ~nextFlag;
        end else begin
            frameCnt <= frameCnt + 1'b1;
            state    <= frameAcquire;
        end
    end

    // valid bits and event strobe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binSeen  <= '0;
            hitValid <= 1'b0;
        end else if (wrap) begin
            binSeen  <= '0;        // invalidate every bin at once
            hitValid <= 1'b0;      // event on the wrap edge is dropped
        end else if (binValid) begin
            binSeen[binAddr] <= 1'b1;
            hitValid         <= 1'b1;
        end else begin
            hitValid <= 1'b0;
        end
    end

    // count storage and result payload
    always_ff @(posedge clk) begin
        if (binValid && !wrap) begin
            binMem[binAddr] <= nextCount;
            hitBin          <= binAddr;
            hitCount        <= nextCount;
        end
    end

    assign cnt.valid     = hitValid;
    assign cnt.bin       = hitBin;
    assign cnt.count     = hitCount;
    assign cnt.frameDone = (state == frameClose);

    aNoCountAtClose: assert property (
        @(posedge clk) disable iff (!res)
        (state == frameClose) |-> !cnt.valid
    ) else $error("hisBuilderReg: count result during frame close");

    aCountNonZero: assert property (
        @(posedge clk) disable iff (!res)
        cnt.valid |-> (cnt.count != '0)
    ) else $error("hisBuilderReg: zero count reported");

endmodule

`default_nettype wire

// File: verilog/binMapper.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

module binMapper import hisBuilderPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   stampValid,
    input  logic [`HIS_TS_W-1:0]   stamp,
    input  hisRes                  resSel,
    input  logic [`HIS_TS_W-1:0]   offset,
    output logic                   binValid,
    output logic [`HIS_BIN_W-1:0]  binAddr,
    output logic                   outOfRange
);

    logic [`HIS_TS_W-1:0] diff;
    logic [`HIS_TS_W-1:0] shifted;
    logic                 belowOffset;
    logic                 inRange;

    assign belowOffset = stamp < offset;
    assign diff        = stamp - offset;  // wraps when below, masked by belowOffset

    always_comb begin
        if (resSel == resCoarse) begin
            shifted = diff >> `HIS_COARSE_SHIFT;
        end else begin
            shifted = diff >> `HIS_FINE_SHIFT;
        end
    end

    // reject anything past the last bin
    assign inRange = !belowOffset && (shifted < `HIS_TS_W'(`HIS_NUM_BINS));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid   <= 1'b0;
            outOfRange <= 1'b0;
        end else begin
            binValid   <= stampValid && inRange;
            outOfRange <= stampValid && !inRange;
        end
    end

    // address only matters while binValid is high
    always_ff @(posedge clk) begin
        binAddr <= shifted[`HIS_BIN_W-1:0];
    end

    aValidExclusive: assert property (
        @(posedge clk) disable iff (!res)
        !(binValid && outOfRange)
    ) else $error("binMapper: binValid and outOfRange high together");

endmodule

`default_nettype wire

// File: verilog/countStream.sv
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_settings.svh"

interface countStream;

    logic                    valid;      // one cycle per counted event
    logic [`HIS_BIN_W-1:0]   bin;
    logic [`HIS_COUNT_W-1:0] count;      // bin count after the event
    logic                    frameDone;  // frame end pulse

    modport src (
        output valid,
        output bin,
        output count,
        output frameDone
    );

    modport dst (
        input valid,
        input bin,
        input count,
        input frameDone
    );

endinterface

`default_nettype wire

// File: verilog/hisBuilderPkg.sv
`default_nettype none
`include "hisBuilder_settings.svh"

package hisBuilderPkg;

    // binning resolution of the mapper
    typedef enum logic {
        resFine   = 1'b0,
        resCoarse = 1'b1
    } hisRes;

    // frame phase of the histogram builder
    // close lasts exactly one cycle after each wrap
    typedef enum logic {
        frameAcquire = 1'b0,
        frameClose   = 1'b1
    } frameState;

endpackage

`default_nettype wire

// File: verilog/hisBuilder_settings.svh
`ifndef HIS_BUILDER_SETTINGS_SVH
`define HIS_BUILDER_SETTINGS_SVH

// histogram geometry
`define HIS_NUM_BINS      64
`define HIS_BIN_W         6
`define HIS_COUNT_W       16   // counts saturate at all ones

// incoming TDC timestamp
`define HIS_TS_W          16

// frame length in clock cycles
`define HIS_FRAME_CYCLES  512

// timestamp to bin shifts
`define HIS_FINE_SHIFT    2
`define HIS_COARSE_SHIFT  5    // wider bins, same bin count

`endif
